//--- verilog/div_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divide group shared definitions
// widths, funct3 op codes, step counts and
// the iterative divider state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package div_pkg;

    typedef logic [63:0] bus64_t;   // operand or result
    typedef logic [31:0] bus32_t;   // W-form word slice

    // funct3 of the divide group
    typedef logic [2:0] div_op_t;

    localparam div_op_t OP_DIV  = 3'd4;
    localparam div_op_t OP_DIVU = 3'd5;
    localparam div_op_t OP_REM  = 3'd6;
    localparam div_op_t OP_REMU = 3'd7;

    // radix-16, four quotient bits per cycle
    localparam int unsigned STEP_BITS = 4;

    // iterations left after the first step
    localparam int unsigned STEPS_64 = 15;
    localparam int unsigned STEPS_32 = 7;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_FIRST,
        DIV_OP,
        DIV_DONE
    } div_state_t;

endpackage

//--- verilog/div_4bits.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// radix-16 division step
// four chained restoring steps per call,
// quotient bits shift in at the low end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module div_4bits (
    input  div_pkg::bus64_t remanent_i,
    input  div_pkg::bus64_t dividend_quotient_i,
    input  div_pkg::bus64_t divisor_i,
    output div_pkg::bus64_t remanent_o,
    output div_pkg::bus64_t dividend_quotient_o,
    output div_pkg::bus64_t divisor_o
);
    import div_pkg::*;

    bus64_t      rem;
    bus64_t      dq;
    logic [64:0] shifted;   // one extra bit, 2*rem+1 can exceed 64 bits

    always_comb begin
        rem     = remanent_i;
        dq      = dividend_quotient_i;
        shifted = '0;
        for (int i = 0; i < STEP_BITS; i++) begin
            shifted = {rem, dq[63]};            // bring down next dividend bit
            dq      = {dq[62:0], 1'b0};
            if (shifted >= {1'b0, divisor_i}) begin
                shifted = shifted - {1'b0, divisor_i};
                dq[0]   = 1'b1;                 // quotient bit
            end
            rem = shifted[63:0];
        end
    end

    assign remanent_o          = rem;
    assign dividend_quotient_o = dq;
    assign divisor_o           = divisor_i;     // held in the same stage

endmodule

//--- verilog/div_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iterative integer divider
// unsigned core on absolute values, 4 bits
// per cycle, sign fixup and divide by zero
// handling on the done cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module div_unit (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            kill_div_i,
    input  logic            request_i,
    input  logic            int_32_i,
    input  logic            signed_op_i,
    input  div_pkg::bus64_t dvnd_i,         // rs1
    input  div_pkg::bus64_t dvsr_i,         // rs2
    output div_pkg::bus64_t quo_o,
    output div_pkg::bus64_t rmd_o,
    output logic            stall_o,
    output logic            done_tick_o
);
    import div_pkg::*;

    div_state_t state_q;
    div_state_t state_d;
    logic [3:0] cnt_q;      // steps still to run in DIV_OP
    logic [3:0] cnt_d;
    logic       start;      // request sampled in idle
    logic       step_en;

    bus64_t dvnd_ext;
    bus64_t dvsr_ext;
    logic   dvnd_neg;
    logic   dvsr_neg;
    bus64_t dvnd_abs;
    bus64_t dvsr_abs;
    logic   div_zero;

    // operation context, captured at the sampling edge
    logic   int_32_q;
    logic   neg_quo_q;
    logic   neg_rmd_q;
    logic   div_zero_q;
    bus64_t dvnd_q;
    bus64_t dvnd_abs_q;
    bus64_t dvsr_abs_q;

    bus64_t remanent_in;
    bus64_t dividend_quotient_in;
    bus64_t divisor_in;
    bus64_t remanent_out;
    bus64_t dividend_quotient_out;
    bus64_t divisor_out;
    bus64_t remanent_q;
    bus64_t dividend_quotient_q;
    bus64_t divisor_q;

    bus64_t quo_fix;
    bus64_t rmd_fix;
    bus32_t quo_w;
    bus32_t rmd_w;

    // extend W operands from bit 31 (signed) or with zeros
    assign dvnd_ext = int_32_i ? {{32{signed_op_i & dvnd_i[31]}}, dvnd_i[31:0]} : dvnd_i;
    assign dvsr_ext = int_32_i ? {{32{signed_op_i & dvsr_i[31]}}, dvsr_i[31:0]} : dvsr_i;

    assign dvnd_neg = signed_op_i & dvnd_ext[63];
    assign dvsr_neg = signed_op_i & dvsr_ext[63];
    assign dvnd_abs = dvnd_neg ? ~dvnd_ext + 64'd1 : dvnd_ext;
    assign dvsr_abs = dvsr_neg ? ~dvsr_ext + 64'd1 : dvsr_ext;

    assign div_zero = int_32_i ? (dvsr_i[31:0] == '0) : (dvsr_i == '0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            int_32_q   <= int_32_i;
            neg_quo_q  <= dvnd_neg ^ dvsr_neg;
            neg_rmd_q  <= dvnd_neg;             // remainder takes dividend sign
            div_zero_q <= div_zero;
            dvnd_q     <= dvnd_i;
            dvnd_abs_q <= dvnd_abs;
            dvsr_abs_q <= dvsr_abs;
        end
    end

    always_ff @(posedge clk_i) begin
        if (step_en) begin
            remanent_q          <= remanent_out;
            dividend_quotient_q <= dividend_quotient_out;
            divisor_q           <= divisor_out;
        end
    end

    always_comb begin
        state_d     = state_q;
        cnt_d       = cnt_q;
        start       = 1'b0;
        step_en     = 1'b0;
        stall_o     = 1'b0;
        done_tick_o = 1'b0;
        case (state_q)
            DIV_IDLE: begin
                if (request_i && !kill_div_i) begin
                    start   = 1'b1;
                    state_d = DIV_FIRST;
                end
            end
            DIV_FIRST: begin
                if (kill_div_i) begin
                    state_d = DIV_IDLE;
                end else begin
                    stall_o = 1'b1;
                    step_en = 1'b1;
                    cnt_d   = int_32_q ? 4'(STEPS_32) : 4'(STEPS_64);
                    state_d = DIV_OP;
                end
            end
            DIV_OP: begin
                if (kill_div_i) begin
                    state_d = DIV_IDLE;
                end else begin
                    stall_o = 1'b1;
                    step_en = 1'b1;
                    cnt_d   = cnt_q - 4'd1;
                    if (cnt_q == 4'd1) begin
                        state_d = DIV_DONE;
                    end
                end
            end
            DIV_DONE: begin
                done_tick_o = !kill_div_i;
                state_d     = DIV_IDLE;
            end
            default: state_d = DIV_IDLE;
        endcase
    end

    // first step starts from a clear remainder, W dividend sits in the upper half
    always_comb begin
        if (state_q == DIV_FIRST) begin
            remanent_in          = '0;
            dividend_quotient_in = int_32_q ? {dvnd_abs_q[31:0], 32'b0} : dvnd_abs_q;
            divisor_in           = dvsr_abs_q;
        end else begin
            remanent_in          = remanent_q;
            dividend_quotient_in = dividend_quotient_q;
            divisor_in           = divisor_q;
        end
    end

    div_4bits div_4bits_i (
        .remanent_i          (remanent_in),
        .dividend_quotient_i (dividend_quotient_in),
        .divisor_i           (divisor_in),
        .remanent_o          (remanent_out),
        .dividend_quotient_o (dividend_quotient_out),
        .divisor_o           (divisor_out)
    );

    // signed overflow falls out of the negation, no special case
    assign quo_fix = div_zero_q ? '1 :
                     (neg_quo_q ? ~dividend_quotient_q + 64'd1 : dividend_quotient_q);
    assign rmd_fix = div_zero_q ? dvnd_q :
                     (neg_rmd_q ? ~remanent_q + 64'd1 : remanent_q);

    assign quo_w = quo_fix[31:0];
    assign rmd_w = rmd_fix[31:0];

    assign quo_o = !done_tick_o ? '0 : (int_32_q ? {{32{quo_w[31]}}, quo_w} : quo_fix);
    assign rmd_o = !done_tick_o ? '0 : (int_32_q ? {{32{rmd_w[31]}}, rmd_w} : rmd_fix);

endmodule

//--- verilog/div_exec.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divide execution unit
// decodes DIV/DIVU/REM/REMU and W forms,
// runs div_unit, returns quotient or remainder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module div_exec (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             valid_i,       // held until result or kill
    input  logic             kill_i,
    input  div_pkg::div_op_t op_i,
    input  logic             word_i,        // W form
    input  div_pkg::bus64_t  rs1_i,
    input  div_pkg::bus64_t  rs2_i,
    output logic             busy_o,
    output logic             result_valid_o,
    output div_pkg::bus64_t  result_o
);
    import div_pkg::*;

    logic   signed_op;
    logic   rem_sel;    // remainder instead of quotient
    bus64_t quo;
    bus64_t rmd;
    logic   stall;
    logic   done_tick;

    always_comb begin
        case (op_i)
            OP_DIV: begin
                signed_op = 1'b1;
                rem_sel   = 1'b0;
            end
            OP_DIVU: begin
                signed_op = 1'b0;
                rem_sel   = 1'b0;
            end
            OP_REM: begin
                signed_op = 1'b1;
                rem_sel   = 1'b1;
            end
            OP_REMU: begin
                signed_op = 1'b0;
                rem_sel   = 1'b1;
            end
            default: begin
                // same bit rules as funct3 for anything else
                signed_op = ~op_i[0];
                rem_sel   = op_i[1];
            end
        endcase
    end

    div_unit div_unit_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .kill_div_i  (kill_i),
        .request_i   (valid_i),
        .int_32_i    (word_i),
        .signed_op_i (signed_op),
        .dvnd_i      (rs1_i),
        .dvsr_i      (rs2_i),
        .quo_o       (quo),
        .rmd_o       (rmd),
        .stall_o     (stall),
        .done_tick_o (done_tick)
    );

    assign busy_o         = stall;
    assign result_valid_o = done_tick;
    assign result_o       = rem_sel ? rmd : quo;   // both zero outside the done cycle

endmodule

//--- sim/div_exec_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divide unit result checker
// reference model of the M-extension divide
// rules, latency and busy/valid assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module div_exec_assert (
    input logic             clk_i,
    input logic             rstn_i,
    input logic             valid_i,
    input logic             kill_i,
    input div_pkg::div_op_t op_i,
    input logic             word_i,
    input div_pkg::bus64_t  rs1_i,
    input div_pkg::bus64_t  rs2_i,
    input logic             busy_o,
    input logic             result_valid_o,
    input div_pkg::bus64_t  result_o
);
    import div_pkg::*;

    int     err_cnt = 0;    // failed checks so far
    logic   active_q;       // operation in flight
    int     cnt_q;          // cycle number after the sampling edge
    int     lat_q;
    bus64_t exp_q;
    string  name_q;
    logic   done_exp;
    logic   busy_exp;

    // W operands are extended to 64 bits first, result cut back to bit 31
    function automatic bus64_t ref_result(div_op_t op, logic word, bus64_t a, bus64_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        bus64_t             q;
        bus64_t             r;
        bus64_t             res;
        if (word) begin
            a = op[0] ? {32'b0, a[31:0]} : {{32{a[31]}}, a[31:0]};
            b = op[0] ? {32'b0, b[31:0]} : {{32{b[31]}}, b[31:0]};
        end
        sa = a;
        sb = b;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (!op[0] && a == {1'b1, 63'b0} && b == '1) begin
            q = a;          // signed overflow
            r = '0;
        end else if (!op[0]) begin
            q = sa / sb;
            r = sa % sb;
        end else begin
            q = a / b;
            r = a % b;
        end
        res = op[1] ? r : q;
        return word ? {{32{res[31]}}, res[31:0]} : res;
    endfunction

    function automatic string op_name(div_op_t op, logic word);
        string base [4] = '{"DIV", "DIVU", "REM", "REMU"};
        return word ? {base[op[1:0]], "W"} : base[op[1:0]];
    endfunction

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            active_q <= 1'b0;
            cnt_q    <= 0;
            lat_q    <= 0;
            exp_q    <= '0;
            name_q   <= "";
        end else if (active_q) begin
            cnt_q <= cnt_q + 1;
            if (kill_i || cnt_q == lat_q) begin
                active_q <= 1'b0;   // killed or done
            end
        end else if (valid_i && !kill_i) begin
            active_q <= 1'b1;
            cnt_q    <= 1;
            lat_q    <= word_i ? 9 : 17;    // done cycle for W / 64-bit
            exp_q    <= ref_result(op_i, word_i, rs1_i, rs2_i);
            name_q   <= op_name(op_i, word_i);
        end
    end

    assign done_exp = active_q && cnt_q == lat_q && !kill_i;
    assign busy_exp = active_q && cnt_q < lat_q && !kill_i;

    a_result: assert property (@(posedge clk_i) result_valid_o |-> result_o == exp_q)
    else begin
        err_cnt++;
        $error("ERR %s expected %h actual %h", name_q, exp_q, result_o);
    end

    a_valid: assert property (@(posedge clk_i) result_valid_o == done_exp)
    else begin
        err_cnt++;
        $error("ERR %s result_valid_o expected %b actual %b", name_q, done_exp, result_valid_o);
    end

    a_busy: assert property (@(posedge clk_i) busy_o == busy_exp)
    else begin
        err_cnt++;
        $error("ERR %s busy_o expected %b actual %b", name_q, busy_exp, busy_o);
    end

    a_idle_zero: assert property (@(posedge clk_i) !result_valid_o |-> result_o == '0)
    else begin
        err_cnt++;
        $error("ERR %s idle result_o expected 0 actual %h", name_q, result_o);
    end

endmodule

//--- sim/tb_div_exec.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divide unit testbench
// directed, random and kill sequences on
// div_exec, results judged by the bound checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_div_exec;
    import div_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 4;
    localparam int N_PAIRS    = 8;      // directed operand pairs
    localparam int N_RANDOM   = 48;
    localparam int N_KILL     = 4;      // each one followed by a clean op
    localparam int N_OPS      = N_PAIRS * 8 + N_RANDOM + 2 * N_KILL;

    logic    clk_i;
    logic    rstn_i;
    logic    valid_i;
    logic    kill_i;
    div_op_t op_i;
    logic    word_i;
    bus64_t  rs1_i;
    bus64_t  rs2_i;
    logic    busy_o;
    logic    result_valid_o;
    bus64_t  result_o;

    int          seed = 34;
    logic [31:0] rnd;
    div_op_t     ops [4] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    // upper halves carry junk for the W forms
    bus64_t dir_a [N_PAIRS] = '{64'h1234_5678_0000_0064, 64'hFFFF_FFFF_FFFF_FF9C,
                                64'h0000_0000_0000_0064, 64'hFFFF_FFFF_FFFF_FF9C,
                                64'h8765_4321_8765_4321, 64'h0123_4567_89AB_CDEF,
                                64'h8000_0000_0000_0000, 64'hDEAD_BEEF_8000_0000};
    bus64_t dir_b [N_PAIRS] = '{64'h0000_0000_0000_0007, 64'hABCD_0000_0000_0007,
                                64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFF9,
                                64'h0000_0000_0000_0000, 64'hFFFF_FFFF_0000_0000,
                                64'hFFFF_FFFF_FFFF_FFFF, 64'h1234_5678_FFFF_FFFF};

    div_exec div_exec_i (.*);

    bind div_exec div_exec_assert div_exec_assert_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic drive_op(input div_op_t op, input logic word, input bus64_t a,
                            input bus64_t b);
        @(negedge clk_i);
        valid_i = 1'b1;
        op_i    = op;
        word_i  = word;
        rs1_i   = a;
        rs2_i   = b;
    endtask

    // request held until the result pulse
    task automatic run_op(input div_op_t op, input logic word, input bus64_t a,
                          input bus64_t b);
        drive_op(op, word, a, b);
        do begin
            @(negedge clk_i);
        end while (!result_valid_o);
        valid_i = 1'b0;
    endtask

    // kill seen in cycle kill_cycle after the sampling edge, 1 is DIV_FIRST
    task automatic kill_op(input div_op_t op, input logic word, input bus64_t a,
                           input bus64_t b, input int kill_cycle);
        drive_op(op, word, a, b);
        repeat (kill_cycle) @(negedge clk_i);
        kill_i = 1'b1;
        @(negedge clk_i);
        kill_i  = 1'b0;
        valid_i = 1'b0;
    endtask

    initial begin
        #(CLK_PERIOD * (RST_CYCLES + 25 * N_OPS));
        $display("Simulation failed");
        $fatal(1, "timeout, the divider stopped returning results");
    end

    always @(negedge clk_i) begin
        if (div_exec_i.div_exec_assert_i.err_cnt != 0) begin
            $display("Simulation failed");
            $fatal(1, "the result checker flagged a mismatch");
        end
    end

    initial begin
        clk_i   = 1'b0;
        rstn_i  = 1'b0;
        valid_i = 1'b0;
        kill_i  = 1'b0;
        op_i    = OP_DIV;
        word_i  = 1'b0;
        rs1_i   = '0;
        rs2_i   = '0;
        repeat (RST_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;

        for (int o = 0; o < 4; o++) begin
            for (int w = 0; w < 2; w++) begin
                for (int p = 0; p < N_PAIRS; p++) begin
                    run_op(ops[o], w[0], dir_a[p], dir_b[p]);
                end
            end
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            run_op({1'b1, rnd[1:0]}, rnd[2], {$random(seed), $random(seed)},
                   {$random(seed), $random(seed)} >> rnd[8:3]);   // wide divisor range
        end

        kill_op(OP_DIV, 1'b0, 64'hFFFF_FFFF_FFFF_FF9C, 64'd7, 1);
        run_op(OP_DIV, 1'b0, 64'hFFFF_FFFF_FFFF_FF9C, 64'd7);
        kill_op(OP_REMU, 1'b0, 64'h0123_4567_89AB_CDEF, 64'd13, 6);    // mid iteration
        run_op(OP_REMU, 1'b0, 64'h0123_4567_89AB_CDEF, 64'd13);
        kill_op(OP_DIVU, 1'b0, 64'hFEDC_BA98_7654_3210, 64'd3, 17);    // on the done cycle
        run_op(OP_DIVU, 1'b0, 64'hFEDC_BA98_7654_3210, 64'd3);
        kill_op(OP_REM, 1'b1, 64'h0000_0000_FFFF_FF9C, 64'd9, 9);
        run_op(OP_REM, 1'b1, 64'h0000_0000_FFFF_FF9C, 64'd9);

        repeat (2) @(negedge clk_i);
        if (div_exec_i.div_exec_assert_i.err_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "the result checker flagged a mismatch");
        end
    end

endmodule

//--- src.f
verilog/div_pkg.sv
verilog/div_4bits.sv
verilog/div_unit.sv
verilog/div_exec.sv
sim/div_exec_assert.sv
sim/tb_div_exec.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the divider testbench
# pass or fail comes from the pass message in the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_div_exec -f src.f \
    && ./obj_dir/Vtb_div_exec +verilator+error+limit+1000 2>&1 | tee /dev/stderr \
    | grep -q "Simulation completed successfully" \
    || { echo "Simulation failed"; exit 1; }
